// ==== common/reg_stall_pkg.sv ====
package reg_stall_pkg;

    // general register file of the x86 integer core
    localparam int NUM_REGS = 8;
    localparam int CNT_W    = 4;

    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [CNT_W-1:0]            pend_cnt_t;
    typedef logic [7:0]                  modrm_t;
    typedef logic [7:0]                  sib_t;

    // esp sits at register number 4
    localparam reg_idx_t   STACK_REG  = 3'd4;
    // mod 00 with rm 101 means disp32 only
    localparam reg_idx_t   NO_BASE_RM = 3'd5;
    localparam reg_idx_t   SIB_RM     = 3'd4;
    localparam reg_idx_t   NO_INDEX   = 3'd4;
    localparam logic [1:0] MOD_REG    = 2'd3;

    // operand type codes as delivered by the decoder
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_REG   = 3'd1,
        OP_SEG   = 3'd2,
        OP_MM    = 3'd3,
        OP_MODRM = 3'd4,
        OP_IMM   = 3'd5,
        OP_MEM   = 3'd6
    } op_type_e;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2
    } reg_size_e;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
    } reg_ref_t;

    // up to two registers read per operand
    typedef struct packed {
        reg_ref_t op0_r0;
        reg_ref_t op0_r1;
        reg_ref_t op1_r0;
        reg_ref_t op1_r1;
    } read_set_t;

    typedef struct packed {
        reg_ref_t issue;
        reg_ref_t retire;
        logic     advance;
    } counter_cmd_t;

    // ah..bh live in the upper byte of eax..ebx
    function automatic reg_idx_t size_fix(input reg_idx_t r, input reg_size_e size);
        reg_idx_t fixed;
        fixed = r;
        if (size == SIZE_BYTE) begin
            fixed[2] = 1'b0;
        end
        return fixed;
    endfunction

endpackage

// ==== rtl/operand_decode.sv ====
`timescale 1ns/10ps

module operand_decode import reg_stall_pkg::*; (
    input  op_type_e     op0,
    input  reg_idx_t     op0_reg,
    input  op_type_e     op1,
    input  reg_idx_t     op1_reg,
    input  reg_size_e    register_size,
    input  modrm_t       mod_rm,
    input  sib_t         sib,
    input  reg_idx_t     wb_reg,
    input  reg_size_e    wb_size,
    input  logic         wb_enable,
    input  logic         next_stage_ready,
    output counter_cmd_t cmd,
    output read_set_t    reads
);

    // modrm and sib fields
    logic [1:0] mod;
    reg_idx_t   rm;
    reg_idx_t   sib_base;
    reg_idx_t   sib_index;

    // size corrected register numbers
    reg_idx_t   op0_fix;
    reg_idx_t   op1_fix;
    reg_idx_t   rm_eff;

    logic       no_base;
    logic       index_used;
    reg_idx_t   modrm_base;
    reg_ref_t   index_ref;
    logic       issue_modrm;

    assign mod       = mod_rm[7:6];
    assign rm        = mod_rm[2:0];
    assign sib_base  = sib[2:0];
    assign sib_index = sib[5:3];

    assign op0_fix = size_fix(op0_reg, register_size);
    assign op1_fix = size_fix(op1_reg, register_size);

    // rm names a register only in register direct mode
    assign rm_eff = (mod == MOD_REG) ? size_fix(rm, register_size) : rm;

    // disp32 only with no base register to read
    assign no_base = (mod == 2'd0) && (rm == NO_BASE_RM);

    // rm 100 with a memory mod pulls the base from the sib byte
    assign modrm_base = ((mod == MOD_REG) || (rm != SIB_RM)) ? rm_eff : sib_base;

    // sib index present unless the index field says none
    assign index_used = (mod != MOD_REG) && (rm == SIB_RM) && (sib_index != NO_INDEX);

    assign index_ref.valid = index_used;
    assign index_ref.idx   = sib_index;

    // first register read by one operand
    function automatic reg_ref_t first_read(
        input op_type_e op,
        input reg_idx_t own_fix,
        input logic     base_absent,
        input reg_idx_t base_reg
    );
        reg_ref_t r;
        r = '0;
        case (op)
            OP_REG, OP_MEM: begin
                r.valid = 1'b1;
                r.idx   = own_fix;
            end
            OP_MODRM: begin
                r.valid = !base_absent;
                r.idx   = base_reg;
            end
            // segment, mm, immediate and none read no general register
            default: begin
                r = '0;
            end
        endcase
        return r;
    endfunction

    // second register only comes from a sib index
    function automatic reg_ref_t second_read(input op_type_e op, input reg_ref_t idx_ref);
        reg_ref_t r;
        r = idx_ref;
        if (op != OP_MODRM) begin
            r.valid = 1'b0;
        end
        return r;
    endfunction

    assign reads.op0_r0 = first_read(op0, op0_fix, no_base, modrm_base);
    assign reads.op0_r1 = second_read(op0, index_ref);
    assign reads.op1_r0 = first_read(op1, op1_fix, no_base, modrm_base);
    assign reads.op1_r1 = second_read(op1, index_ref);

    // op0 writes a register when it is a plain register or modrm with mod 11
    assign issue_modrm     = (op0 == OP_MODRM) && (mod == MOD_REG);
    assign cmd.issue.valid = (op0 == OP_REG) || issue_modrm;
    assign cmd.issue.idx   = issue_modrm ? rm_eff : op0_fix;

    // writeback always retires since that side has no back-pressure
    assign cmd.retire.valid = wb_enable;
    assign cmd.retire.idx   = size_fix(wb_reg, wb_size);

    // only count the write once the instruction moves on
    assign cmd.advance = next_stage_ready;

endmodule

// ==== rtl/register_access_stall.sv ====
`timescale 1ns/10ps

module register_access_stall import reg_stall_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      stack_op,
    input  reg_size_e register_size,
    input  op_type_e  op0,
    input  reg_idx_t  op0_reg,
    input  op_type_e  op1,
    input  reg_idx_t  op1_reg,
    input  modrm_t    mod_rm,
    input  sib_t      sib,
    input  reg_idx_t  wb_reg,
    input  reg_size_e wb_size,
    input  logic      wb_enable,
    input  logic      next_stage_ready,
    // high while a read depends on an older pending write
    output logic      is_stall
);

    counter_cmd_t cmd;
    read_set_t    reads;
    pend_cnt_t    counts [NUM_REGS];

    // decode reads, the op0 write target and the retire request
    operand_decode u_decode (
        .op0              (op0),
        .op0_reg          (op0_reg),
        .op1              (op1),
        .op1_reg          (op1_reg),
        .register_size    (register_size),
        .mod_rm           (mod_rm),
        .sib              (sib),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .wb_enable        (wb_enable),
        .next_stage_ready (next_stage_ready),
        .cmd              (cmd),
        .reads            (reads)
    );

    // one pending-write counter per general register
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_slot
        pending_counter u_counter (
            .clk      (clk),
            .arst_n   (arst_n),
            .slot_reg (reg_idx_t'(i)),
            .cmd      (cmd),
            .count    (counts[i])
        );
    end

    hazard_check u_hazard (
        .counts   (counts),
        .reads    (reads),
        .stack_op (stack_op),
        .is_stall (is_stall)
    );

endmodule

// ==== scoreboard/hazard_check.sv ====
`timescale 1ns/10ps

module hazard_check import reg_stall_pkg::*; (
    input  pend_cnt_t counts [NUM_REGS],
    input  read_set_t reads,
    input  logic      stack_op,
    output logic      is_stall
);

    // the four read references as an indexable list
    reg_ref_t   refs [4];
    logic [3:0] read_hit;
    logic       stack_hit;

    assign refs[0] = reads.op0_r0;
    assign refs[1] = reads.op0_r1;
    assign refs[2] = reads.op1_r0;
    assign refs[3] = reads.op1_r1;

    // a read hazards when its register still has writes in flight
    always_comb begin
        foreach (refs[i]) begin
            read_hit[i] = refs[i].valid && (counts[refs[i].idx] != '0);
        end
    end

    // push and pop touch esp implicitly
    assign stack_hit = stack_op && (counts[STACK_REG] != '0);

    assign is_stall = (|read_hit) || stack_hit;

endmodule

// ==== scoreboard/pending_counter.sv ====
`timescale 1ns/10ps

module pending_counter import reg_stall_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    // register number this slot tracks
    input  reg_idx_t     slot_reg,
    input  counter_cmd_t cmd,
    output pend_cnt_t    count
);

    logic issue_hit;
    logic retire_hit;
    logic do_inc;
    logic do_dec;

    // issue counts only when the instruction is accepted downstream
    assign issue_hit = cmd.issue.valid && (cmd.issue.idx == slot_reg);

    assign retire_hit = cmd.retire.valid && (cmd.retire.idx == slot_reg);

    assign do_inc = issue_hit && cmd.advance;
    assign do_dec = retire_hit;

    // simultaneous issue and retire cancel out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (do_inc && !do_dec) begin
            count <= count + pend_cnt_t'(1);
        end else if (do_dec && !do_inc) begin
            // never underflows while writebacks match earlier issues
            count <= count - pend_cnt_t'(1);
        end
    end

endmodule

// ==== sim/register_access_stall_vectors.txt ====
# stack_op register_size op0 op0_reg op1 op1_reg mod_rm sib wb_reg wb_size wb_enable
# next_stage_ready expected_is_stall, all hex; sizes 0 byte 2 dword; types 0 none 1 reg 4 modrm 6 mem
# after reset every counter is clear
0 2 6 0 1 1 00 00 0 2 0 1 0
0 2 6 2 1 3 00 00 0 2 0 1 0
0 2 6 4 1 5 00 00 0 2 0 1 0
0 2 6 6 1 7 00 00 0 2 0 1 0
0 2 4 0 0 0 44 30 0 2 0 1 0
0 2 0 0 4 0 c4 00 0 2 0 1 0
1 2 0 0 0 0 00 00 0 2 0 1 0
0 0 6 7 1 6 00 00 0 2 0 1 0
# pending write on r3
0 2 1 3 0 0 00 00 0 2 0 1 0
0 2 0 0 1 3 00 00 0 2 0 1 1
0 2 0 0 1 2 00 00 0 2 0 1 0
0 2 6 3 0 0 00 00 0 2 0 0 1
0 2 0 0 0 0 00 00 3 2 1 1 0
0 2 0 0 1 3 00 00 0 2 0 1 0
# same write with next stage not ready
0 2 1 3 0 0 00 00 0 2 0 0 0
0 2 0 0 1 3 00 00 0 2 0 1 0
0 2 6 3 1 3 00 00 0 2 0 1 0
# two writes to r1 retired one by one
0 2 1 1 0 0 00 00 0 2 0 1 0
0 2 1 1 0 0 00 00 0 2 0 1 1
0 2 0 0 1 1 00 00 0 2 0 1 1
0 2 0 0 1 1 00 00 1 2 1 1 1
0 2 0 0 1 1 00 00 0 2 0 1 1
0 2 0 0 0 0 00 00 1 2 1 0 0
0 2 0 0 1 1 00 00 0 2 0 1 0
# issue and writeback of r1 in one cycle
0 2 1 1 0 0 00 00 0 2 0 1 0
0 2 1 1 0 0 00 00 1 2 1 1 1
0 2 0 0 1 1 00 00 0 2 0 1 1
0 2 0 0 0 0 00 00 1 2 1 1 0
0 2 0 0 1 1 00 00 0 2 0 1 0
# byte size maps r4..r7 onto r0..r3
0 2 1 1 0 0 00 00 0 2 0 1 0
0 0 0 0 1 5 00 00 0 2 0 1 1
0 2 0 0 1 5 00 00 0 2 0 1 0
0 2 0 0 0 0 00 00 5 0 1 1 0
0 2 0 0 1 1 00 00 0 2 0 1 0
0 2 0 0 1 5 00 00 0 2 0 1 0
0 2 6 5 6 1 00 00 0 2 0 1 0
0 0 1 6 0 0 00 00 0 2 0 1 0
0 2 0 0 1 2 00 00 0 2 0 1 1
0 2 0 0 1 6 00 00 0 2 0 1 0
0 2 0 0 0 0 00 00 2 2 1 1 0
0 2 0 0 1 2 00 00 0 2 0 1 0
# modrm and sib with writes pending on r0 and r6
0 2 1 0 0 0 00 00 0 2 0 1 0
0 2 1 6 0 0 00 00 0 2 0 1 0
0 2 0 0 4 0 44 30 0 2 0 1 1
0 2 0 0 4 0 44 22 0 2 0 1 0
0 2 0 0 4 0 44 32 0 2 0 1 1
0 2 0 0 4 0 44 20 0 2 0 1 1
0 2 0 0 4 0 84 22 0 2 0 1 0
0 2 4 0 0 0 44 22 0 2 0 1 0
0 2 0 0 4 0 05 30 0 2 0 1 0
0 2 0 0 4 0 00 00 0 2 0 1 1
0 2 0 0 4 0 46 00 0 2 0 1 1
0 2 0 0 4 0 86 00 0 2 0 1 1
0 2 0 0 4 0 02 00 0 2 0 1 0
0 0 0 0 4 0 c4 00 0 2 0 1 1
0 2 0 0 4 0 c4 30 0 2 0 1 0
0 2 0 0 4 0 c6 00 0 2 0 1 1
0 0 0 0 4 0 c6 00 0 2 0 1 0
0 0 0 0 4 0 46 00 0 2 0 1 1
0 2 0 0 2 0 00 00 0 2 0 1 0
0 2 0 0 3 0 00 00 0 2 0 1 0
0 2 0 0 5 0 00 00 0 2 0 1 0
0 2 5 0 3 6 00 00 0 2 0 1 0
0 2 0 0 0 0 00 00 0 2 1 1 0
0 2 0 0 4 0 44 30 0 2 0 1 1
0 2 0 0 4 0 44 20 0 2 0 1 0
0 2 0 0 0 0 00 00 6 2 1 1 0
0 2 0 0 4 0 44 30 0 2 0 1 0
# op0 modrm with mod 3 writes the rm register
0 0 4 0 0 0 c7 00 0 2 0 1 0
0 2 0 0 1 3 00 00 0 2 0 1 1
0 2 0 0 1 7 00 00 0 2 0 1 0
0 2 4 0 0 0 47 00 0 2 0 1 0
0 2 0 0 1 7 00 00 0 2 0 1 0
0 2 0 0 0 0 00 00 3 2 1 1 0
0 2 0 0 1 3 00 00 0 2 0 1 0
# stack pointer
0 2 1 4 0 0 00 00 0 2 0 1 0
1 2 0 0 0 0 00 00 0 2 0 1 1
0 2 0 0 0 0 00 00 0 2 0 1 0
0 0 0 0 1 4 00 00 0 2 0 1 0
0 2 0 0 1 4 00 00 0 2 0 1 1
1 2 0 0 0 0 00 00 0 2 0 0 1
0 2 0 0 0 0 00 00 4 2 1 1 0
1 2 0 0 0 0 00 00 0 2 0 1 0
0 2 0 0 1 4 00 00 0 2 0 1 0
1 2 4 0 0 0 44 30 0 2 0 1 0

// ==== sim/tb_register_access_stall.sv ====
`timescale 1ns/10ps

module tb_register_access_stall import reg_stall_pkg::*; ();

    localparam string       VEC_FILE  = "sim/register_access_stall_vectors.txt";
    localparam int          PERIOD    = 4;
    localparam int          NUM_COLS  = 13;
    localparam logic [15:0] LFSR_SEED = 16'd58853;

    // DUT inputs
    logic      clk;
    logic      arst_n;
    logic      stack_op;
    reg_size_e register_size;
    op_type_e  op0;
    reg_idx_t  op0_reg;
    op_type_e  op1;
    reg_idx_t  op1_reg;
    modrm_t    mod_rm;
    sib_t      sib;
    reg_idx_t  wb_reg;
    reg_size_e wb_size;
    logic      wb_enable;
    logic      next_stage_ready;
    logic      is_stall;

    // one parsed vector line, last column is the expected stall
    logic [7:0]  fields [NUM_COLS];
    logic        exp_stall;
    logic [15:0] lfsr_state;
    int          file_line;
    int          vectors_applied;
    int          mismatch_errors;
    int          format_errors;
    int          run_errors;

    register_access_stall dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .stack_op         (stack_op),
        .register_size    (register_size),
        .op0              (op0),
        .op0_reg          (op0_reg),
        .op1              (op1),
        .op1_reg          (op1_reg),
        .mod_rm           (mod_rm),
        .sib              (sib),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .wb_enable        (wb_enable),
        .next_stage_ready (next_stage_ready),
        .is_stall         (is_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int width, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    // blank lines and # comments carry no vector
    function automatic bit is_filler(input string text);
        for (int i = 0; i < text.len(); i++) begin
            if (text[i] == "#") begin
                return 1'b1;
            end
            if (text[i] != " " && text[i] != "\t" && text[i] != "\n" && text[i] != "\r") begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic count_lines(output int lines);
        int    fd;
        string text;
        lines = 0;
        fd    = $fopen(VEC_FILE, "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
    endtask

    task automatic read_data_line(input int fd, output string text, output bit found);
        int got;
        found = 1'b0;
        text  = "";
        got   = 1;
        while (!found && got != 0) begin
            got = $fgets(text, fd);
            if (got != 0) begin
                file_line++;
                found = !is_filler(text);
            end
        end
    endtask

    // enum codes and single bits must stay inside their legal range
    function automatic bit fields_in_range();
        bit ok;
        ok = (fields[0] <= 1) && (fields[1] <= 2) && (fields[2] <= 6) && (fields[3] <= 7)
            && (fields[4] <= 6) && (fields[5] <= 7) && (fields[8] <= 7) && (fields[9] <= 2)
            && (fields[10] <= 1) && (fields[11] <= 1) && (fields[12] <= 1);
        return ok;
    endfunction

    // only register and memory operands read their own register field
    function automatic bit uses_own_reg(input op_type_e op);
        return (op == OP_REG) || (op == OP_MEM);
    endfunction

    task automatic apply_fields();
        logic [7:0] r;
        stack_op         = fields[0][0];
        register_size    = reg_size_e'(fields[1][1:0]);
        op0              = op_type_e'(fields[2][2:0]);
        op0_reg          = fields[3][2:0];
        op1              = op_type_e'(fields[4][2:0]);
        op1_reg          = fields[5][2:0];
        mod_rm           = fields[6];
        sib              = fields[7];
        wb_reg           = fields[8][2:0];
        wb_size          = reg_size_e'(fields[9][1:0]);
        wb_enable        = fields[10][0];
        next_stage_ready = fields[11][0];
        exp_stall        = fields[12][0];
        // scramble the fields that cannot reach the stall
        if (!uses_own_reg(op0)) begin
            random_bits(3, r);
            op0_reg = r[2:0];
        end
        if (!uses_own_reg(op1)) begin
            random_bits(3, r);
            op1_reg = r[2:0];
        end
        if (op0 != OP_MODRM && op1 != OP_MODRM) begin
            random_bits(8, r);
            mod_rm = r;
            random_bits(8, r);
            sib = r;
        end
        if (!wb_enable) begin
            random_bits(3, r);
            wb_reg = r[2:0];
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d is_stall mismatches, %0d malformed vectors, %0d run errors",
                 mismatch_errors, format_errors, run_errors);
        if (mismatch_errors + format_errors + run_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        int    fd;
        int    total_lines;
        int    cycle_limit;
        int    cycles;
        int    n;
        string text;
        bit    found;
        bit    timed_out;
        arst_n           = 1'b0;
        stack_op         = 1'b0;
        register_size    = SIZE_DWORD;
        op0              = OP_NONE;
        op0_reg          = '0;
        op1              = OP_NONE;
        op1_reg          = '0;
        mod_rm           = '0;
        sib              = '0;
        wb_reg           = '0;
        wb_size          = SIZE_DWORD;
        wb_enable        = 1'b0;
        next_stage_ready = 1'b0;
        exp_stall        = 1'b0;
        lfsr_state       = LFSR_SEED;
        file_line        = 0;
        vectors_applied  = 0;
        mismatch_errors  = 0;
        format_errors    = 0;
        run_errors       = 0;
        cycles           = 0;
        timed_out        = 1'b0;
        found            = 1'b0;

        count_lines(total_lines);
        cycle_limit = total_lines + 20;
        fd = $fopen(VEC_FILE, "r");
        assert (fd != 0) else begin
            $display("could not open the vector file %s", VEC_FILE);
            run_errors++;
        end

        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;

        if (fd != 0) begin
            read_data_line(fd, text, found);
        end
        // one vector per clock, driven 1 ns after the edge and checked 1 ns before the next
        while (found && !timed_out) begin
            if (cycles >= cycle_limit) begin
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
                #1;
                n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fields[0], fields[1], fields[2], fields[3], fields[4],
                            fields[5], fields[6], fields[7], fields[8], fields[9],
                            fields[10], fields[11], fields[12]);
                assert (n == NUM_COLS && fields_in_range()) else begin
                    $display("malformed vector on line %0d of the vector file", file_line);
                    format_errors++;
                end
                if (n == NUM_COLS && fields_in_range()) begin
                    apply_fields();
                    vectors_applied++;
                    #2;
                    assert (is_stall === exp_stall) else begin
                        $display("[ERROR] time %0t: is_stall expected %0b, got %0b (line %0d)",
                                 $time, exp_stall, is_stall, file_line);
                        mismatch_errors++;
                    end
                end
                read_data_line(fd, text, found);
            end
        end

        assert (!timed_out) else begin
            $display("timeout: vectors were still left after %0d cycles", cycles);
            run_errors++;
        end
        assert (vectors_applied > 0) else begin
            $display("no vector was applied to the DUT");
            run_errors++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        finish_run();
    end

endmodule

// ==== sources.f ====
common/reg_stall_pkg.sv
rtl/operand_decode.sv
scoreboard/pending_counter.sv
scoreboard/hazard_check.sv
rtl/register_access_stall.sv
sim/tb_register_access_stall.sv
